// ==== compile.f ====
+incdir+src
src/rnn_pkg.sv
src/layer_sequencer.sv
src/mac_unit.sv
src/state_buffers.sv
src/rnn_cell_top.sv
test/rnn_cell_asserts.sv
test/rnn_cell_tb.sv

// ==== Bender.yml ====
package:
  name: rnn_cell

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rnn_pkg.sv
      - src/layer_sequencer.sv
      - src/mac_unit.sv
      - src/state_buffers.sv
      - src/rnn_cell_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/rnn_cell_asserts.sv
      - test/rnn_cell_tb.sv

// ==== test/rnn_cell_tb.sv ====
`timescale 1ns/1ps
`include "rnn_defs.svh"

module rnn_cell_tb;
    import rnn_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam int NUM_OPS  = `EMBEDDING_SIZE
                              + `LINEAR_SIZE * (`LINEAR_SIZE + `EMBEDDING_SIZE + 2);

    logic                  clk;
    logic                  reset;
    logic                  execute;
    token_t                token;
    logic [`HID_IDX_W-1:0] readout_index;
    word_t                 mem_data  = '0;
    logic                  mem_valid = 1'b0;
    logic                  mem_req;
    addr_t                 mem_addr;
    logic                  busy;
    logic                  done;
    word_t                 readout_value;

    // Latency 0 means random 1 to 6 per request
    string  row_name  [NUM_ROWS] = '{"first_step", "second_step", "third_step", "fourth_step",
                                     "lat_one", "lat_three", "lat_random", "busy_execute"};
    token_t row_token [NUM_ROWS] = '{7'd5, 7'd42, 7'd75, 7'd0, 7'd17, 7'd17, 7'd17, 7'd63};
    int     row_lat   [NUM_ROWS] = '{1, 1, 3, 0, 1, 3, 0, 3};
    bit     row_reset [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
    bit     row_extra [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    word_t       mem_model  [`MEM_WORDS];
    word_t       prev_model [`LINEAR_SIZE];
    word_t       expected   [`LINEAR_SIZE];
    int          step_len   [NUM_ROWS];
    logic [31:0] rng_state;
    int          latency_mode;
    int          mismatch_count;
    int          other_count;
    int          cycle_count;
    int          cycle_limit;
    logic        pending;
    addr_t       req_addr;
    int          wait_count;

    rnn_cell_top UUT (
        .clk           (clk),
        .reset         (reset),
        .execute       (execute),
        .token         (token),
        .readout_index (readout_index),
        .mem_data      (mem_data),
        .mem_valid     (mem_valid),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .busy          (busy),
        .done          (done),
        .readout_value (readout_value)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Q8.8 product keeps bits 23:8 of the full 32-bit product
    function automatic word_t scaled_product(word_t a, word_t b);
        logic signed [31:0] p;
        p = a * b;
        return p[23:8];
    endfunction

    function automatic int worst_step(int lat);
        int max_lat;
        max_lat = (lat == 0) ? 6 : lat;
        return NUM_OPS * (max_lat + 1) + `LINEAR_SIZE * 4 + 40;    // 40 for reset and readout
    endfunction

    task automatic check_word(string name, word_t exp_value, word_t act_value);
        assert (act_value === exp_value)
        else
        begin
            $display("Mismatch %s: expected %h, actual %h", name, exp_value, act_value);
            mismatch_count++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond === 1'b1)
        else
        begin
            $display("Error: %s", what);
            other_count++;
        end
    endtask

    task automatic compute_expected(token_t tok);
        word_t sum;
        for (int j = 0; j < `LINEAR_SIZE; j++)
        begin
            sum = '0;
            for (int n = 0; n < `LINEAR_SIZE; n++)
                sum += scaled_product(mem_model[`WHH_BASE + j*`LINEAR_SIZE + n], prev_model[n]);
            sum += mem_model[`BHH_BASE + j];
            for (int k = 0; k < `EMBEDDING_SIZE; k++)
                sum += scaled_product(mem_model[`WIH_BASE + j*`EMBEDDING_SIZE + k],
                                      mem_model[`EMB_BASE + tok*`EMBEDDING_SIZE + k]);
            sum += mem_model[`BIH_BASE + j];
            expected[j] = sum;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < `LINEAR_SIZE; n++)
            prev_model[n] = '0;
    endtask

    task automatic run_row(int i);
        int cycles;
        logic [`HID_IDX_W-1:0] shown;
        if (row_reset[i])
            apply_reset();
        compute_expected(row_token[i]);
        latency_mode = row_lat[i];
        @(negedge clk);
        execute = 1'b1;
        token   = row_token[i];
        shown   = readout_index;
        cycles  = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            execute = row_extra[i] && (cycles == 10);   // Second execute lands mid-step
            token   = row_token[i] + 7'd1;
            check_word($sformatf("%s_during[%0d]", row_name[i], shown),
                       prev_model[shown], readout_value);
            shown         = shown + 1'b1;
            readout_index = shown;
        end
        while (!done);
        step_len[i] = cycles;
        repeat (4)
        begin
            @(negedge clk);
            check_true(!done, $sformatf("%s: second done pulse", row_name[i]));
            check_true(!busy, $sformatf("%s: busy again after done", row_name[i]));
        end
        for (int n = 0; n < `LINEAR_SIZE; n++)
        begin
            readout_index = n;
            @(negedge clk);
            check_word($sformatf("%s[%0d]", row_name[i], n), expected[n], readout_value);
            prev_model[n] = expected[n];
        end
    endtask

    // Memory model serving one request at a time
    always @(negedge clk)
    begin
        mem_valid = 1'b0;
        if (reset)
            pending = 1'b0;
        else if (pending)
        begin
            if (wait_count <= 1)
            begin
                mem_valid = 1'b1;
                mem_data  = mem_model[req_addr];
                pending   = 1'b0;
            end
            else
                wait_count--;
        end
        else if (mem_req)
        begin
            pending  = 1'b1;
            req_addr = mem_addr;
            if (latency_mode == 0)
            begin
                rng_state  = xorshift32(rng_state);
                wait_count = 1 + rng_state % 6;
            end
            else
                wait_count = latency_mode;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        execute        = 1'b0;
        token          = '0;
        readout_index  = '0;
        pending        = 1'b0;
        latency_mode   = 1;
        mismatch_count = 0;
        other_count    = 0;
        cycle_count    = 0;
        rng_state      = 32'h41c9_c7cc;
        for (int a = 0; a < `MEM_WORDS; a++)
        begin
            rng_state    = xorshift32(rng_state);
            mem_model[a] = word_t'(int'(rng_state % 32'd1025) - 512);    // Within +-2.0
        end
        cycle_limit = 40;
        for (int i = 0; i < NUM_ROWS; i++)
            cycle_limit += worst_step(row_lat[i]);
        cycle_limit = 2 * cycle_limit;

        apply_reset();
        check_true(!busy, "busy is high after reset");
        check_true(!done, "done is high after reset");
        check_true(!mem_req, "mem_req is high after reset");
        for (int n = 0; n < `LINEAR_SIZE; n++)
        begin
            readout_index = n;
            @(negedge clk);
            check_word($sformatf("after_reset[%0d]", n), '0, readout_value);
        end

        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);

        // Longer memory latency gives a longer step for the same token and state
        check_true(step_len[5] > step_len[4], "latency 3 step is not longer than latency 1");
        check_true(step_len[6] > step_len[4], "random latency step is not longer than latency 1");

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== test/rnn_cell_asserts.sv ====
`timescale 1ns/1ps
`include "rnn_defs.svh"

module rnn_cell_asserts (
    input logic           clk,
    input logic           reset,
    input logic           mem_req,
    input logic           mem_valid,
    input rnn_pkg::addr_t mem_addr,
    input logic           busy,
    input logic           done
);
    logic outstanding;

    always_ff @(posedge clk)
    begin
        if (reset)
            outstanding <= 1'b0;
        else if (mem_req)
            outstanding <= 1'b1;
        else if (mem_valid)
            outstanding <= 1'b0;
    end

    single_request: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> !outstanding)
        else $error("Memory request issued while another is outstanding");

    // Held from the request cycle through the last wait cycle
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_req || (outstanding && !mem_valid)) |=> $stable(mem_addr))
        else $error("mem_addr changed while a request was outstanding");

    addr_in_range: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> (mem_addr < `MEM_WORDS))
        else $error("mem_addr beyond the end of the word memory");

    busy_ends_with_done: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(done))
        else $error("busy dropped without a done pulse");

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> (!done && !busy))
        else $error("done longer than one cycle or busy stayed high after it");

endmodule

bind rnn_cell_top rnn_cell_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .busy      (busy),
    .done      (done)
);

// ==== src/rnn_cell_top.sv ====
`timescale 1ns/1ps
`include "rnn_defs.svh"

module rnn_cell_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  execute,
    input  rnn_pkg::token_t       token,
    input  logic [`HID_IDX_W-1:0] readout_index,
    input  rnn_pkg::word_t        mem_data,
    input  logic                  mem_valid,
    output logic                  mem_req,
    output rnn_pkg::addr_t        mem_addr,
    output logic                  busy,
    output logic                  done,
    output rnn_pkg::word_t        readout_value
);
    import rnn_pkg::*;

    logic                  emb_write;
    logic [`EMB_IDX_W-1:0] emb_index;
    operand_src_t          operand_src;
    logic [`HID_IDX_W-1:0] operand_index;
    logic                  acc_clear;
    logic                  term_valid;
    logic                  term_is_bias;
    logic                  hidden_write;
    logic [`HID_IDX_W-1:0] hidden_index;
    logic                  commit;
    logic                  pipe_empty;
    word_t                 acc_value;
    word_t                 operand;

    layer_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .execute       (execute),
        .token         (token),
        .mem_valid     (mem_valid),
        .pipe_empty    (pipe_empty),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .busy          (busy),
        .done          (done),
        .emb_write     (emb_write),
        .emb_index     (emb_index),
        .operand_src   (operand_src),
        .operand_index (operand_index),
        .acc_clear     (acc_clear),
        .term_valid    (term_valid),
        .term_is_bias  (term_is_bias),
        .hidden_write  (hidden_write),
        .hidden_index  (hidden_index),
        .commit        (commit)
    );

    mac_unit u_mac (
        .clk          (clk),
        .reset        (reset),
        .acc_clear    (acc_clear),
        .term_valid   (term_valid),
        .term_is_bias (term_is_bias),
        .weight       (mem_data),           // Weight or bias straight from memory
        .operand      (operand),
        .acc_value    (acc_value),
        .pipe_empty   (pipe_empty)
    );

    state_buffers u_buffers (
        .clk           (clk),
        .reset         (reset),
        .emb_write     (emb_write),
        .emb_index     (emb_index),
        .emb_data      (mem_data),
        .operand_src   (operand_src),
        .operand_index (operand_index),
        .hidden_write  (hidden_write),
        .hidden_index  (hidden_index),
        .hidden_data   (acc_value),
        .commit        (commit),
        .readout_index (readout_index),
        .operand       (operand),
        .readout_value (readout_value)
    );

endmodule

// ==== src/state_buffers.sv ====
`timescale 1ns/1ps
`include "rnn_defs.svh"

module state_buffers (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  emb_write,
    input  logic [`EMB_IDX_W-1:0] emb_index,
    input  rnn_pkg::word_t        emb_data,
    input  rnn_pkg::operand_src_t operand_src,
    input  logic [`HID_IDX_W-1:0] operand_index,
    input  logic                  hidden_write,
    input  logic [`HID_IDX_W-1:0] hidden_index,
    input  rnn_pkg::word_t        hidden_data,
    input  logic                  commit,
    input  logic [`HID_IDX_W-1:0] readout_index,
    output rnn_pkg::word_t        operand,
    output rnn_pkg::word_t        readout_value
);
    import rnn_pkg::*;

    word_t emb_buf     [`EMBEDDING_SIZE];
    word_t new_hidden  [`LINEAR_SIZE];
    word_t prev_hidden [`LINEAR_SIZE];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `EMBEDDING_SIZE; i++)
                emb_buf[i] <= '0;
        end
        else if (emb_write)
            emb_buf[emb_index] <= emb_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `LINEAR_SIZE; i++)
            begin
                new_hidden[i]  <= '0;
                prev_hidden[i] <= '0;
            end
        end
        else
        begin
            if (hidden_write)
                new_hidden[hidden_index] <= hidden_data;
            if (commit)
                prev_hidden <= new_hidden;      // Whole vector in one cycle
        end
    end

    always_comb
    begin
        if (operand_src == SRC_EMB)
            operand = emb_buf[operand_index[`EMB_IDX_W-1:0]];
        else
            operand = prev_hidden[operand_index];
    end

    // Readout shows the committed state only
    assign readout_value = prev_hidden[readout_index];

endmodule

// ==== src/mac_unit.sv ====
`timescale 1ns/1ps
`include "rnn_defs.svh"

module mac_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           acc_clear,
    input  logic           term_valid,
    input  logic           term_is_bias,
    input  rnn_pkg::word_t weight,
    input  rnn_pkg::word_t operand,
    output rnn_pkg::word_t acc_value,
    output logic           pipe_empty
);
    import rnn_pkg::*;

    logic signed [2*`WORD_W-1:0] product;
    logic signed [2*`WORD_W-1:0] scaled;
    word_t                       stage_value;
    logic                        stage_valid;
    word_t                       acc;

    assign product = weight * operand;
    assign scaled  = product >>> `FRAC_BITS;      // Back to Q8.8

    always_ff @(posedge clk)
    begin
        if (reset)
            stage_valid <= 1'b0;
        else
            stage_valid <= term_valid;
    end

    always_ff @(posedge clk)
    begin
        if (term_valid)
            stage_value <= term_is_bias ? weight : scaled[`WORD_W-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (reset || acc_clear)
            acc <= '0;
        else if (stage_valid)
            acc <= acc + stage_value;             // Wraps at 16 bits
    end

    assign acc_value  = acc;
    assign pipe_empty = ~stage_valid;

endmodule

// ==== src/layer_sequencer.sv ====
`timescale 1ns/1ps
`include "rnn_defs.svh"

module layer_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  execute,
    input  rnn_pkg::token_t       token,
    input  logic                  mem_valid,
    input  logic                  pipe_empty,
    output logic                  mem_req,
    output rnn_pkg::addr_t        mem_addr,
    output logic                  busy,
    output logic                  done,
    output logic                  emb_write,
    output logic [`EMB_IDX_W-1:0] emb_index,
    output rnn_pkg::operand_src_t operand_src,
    output logic [`HID_IDX_W-1:0] operand_index,
    output logic                  acc_clear,
    output logic                  term_valid,
    output logic                  term_is_bias,
    output logic                  hidden_write,
    output logic [`HID_IDX_W-1:0] hidden_index,
    output logic                  commit
);
    import rnn_pkg::*;

    seq_state_t            state;
    seq_state_t            next_state;
    token_t                token_q;
    logic [`HID_IDX_W-1:0] neuron_count;
    logic [`HID_IDX_W-1:0] next_neuron_count;
    logic [`HID_IDX_W-1:0] term_count;
    logic [`HID_IDX_W-1:0] next_term_count;
    logic                  last_emb_term;
    logic                  last_hid_term;
    logic                  last_neuron;

    assign last_emb_term = (term_count == `EMBEDDING_SIZE - 1);
    assign last_hid_term = (term_count == `LINEAR_SIZE - 1);
    assign last_neuron   = (neuron_count == `LINEAR_SIZE - 1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= S_IDLE;
            neuron_count <= '0;
            term_count   <= '0;
        end
        else
        begin
            state        <= next_state;
            neuron_count <= next_neuron_count;
            term_count   <= next_term_count;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && execute)
            token_q <= token;
    end

    always_comb
    begin
        next_state        = state;
        next_neuron_count = neuron_count;
        next_term_count   = term_count;
        case (state)
            S_IDLE:
            begin
                if (execute)
                begin
                    next_neuron_count = '0;
                    next_term_count   = '0;
                    next_state        = S_EMB_REQ;
                end
            end
            S_EMB_REQ:  next_state = S_EMB_WAIT;
            S_EMB_WAIT:
            begin
                if (mem_valid)
                begin
                    next_term_count = last_emb_term ? '0 : term_count + 1'b1;
                    next_state      = last_emb_term ? S_CLEAR : S_EMB_REQ;
                end
            end
            S_CLEAR:    next_state = S_HH_REQ;      // Accumulator zeroed here
            S_HH_REQ:   next_state = S_HH_WAIT;
            S_HH_WAIT:
            begin
                if (mem_valid)
                begin
                    next_term_count = last_hid_term ? '0 : term_count + 1'b1;
                    next_state      = last_hid_term ? S_BHH_REQ : S_HH_REQ;
                end
            end
            S_BHH_REQ:  next_state = S_BHH_WAIT;
            S_BHH_WAIT:
            begin
                if (mem_valid)
                    next_state = S_IH_REQ;
            end
            S_IH_REQ:   next_state = S_IH_WAIT;
            S_IH_WAIT:
            begin
                if (mem_valid)
                begin
                    next_term_count = last_emb_term ? '0 : term_count + 1'b1;
                    next_state      = last_emb_term ? S_BIH_REQ : S_IH_REQ;
                end
            end
            S_BIH_REQ:  next_state = S_BIH_WAIT;
            S_BIH_WAIT:
            begin
                if (mem_valid)
                    next_state = S_DRAIN;
            end
            S_DRAIN:
            begin
                // Last term must reach the accumulator before the write
                if (pipe_empty)
                begin
                    if (last_neuron)
                        next_state = S_COMMIT;
                    else
                    begin
                        next_neuron_count = neuron_count + 1'b1;
                        next_state        = S_CLEAR;
                    end
                end
            end
            S_COMMIT:   next_state = S_IDLE;
            default:    next_state = S_IDLE;
        endcase
    end

    // Address held through the request and wait cycles
    always_comb
    begin
        case (state)
            S_EMB_REQ, S_EMB_WAIT:
                mem_addr = addr_t'(`EMB_BASE + token_q * `EMBEDDING_SIZE + term_count);
            S_HH_REQ, S_HH_WAIT:
                mem_addr = addr_t'(`WHH_BASE + neuron_count * `LINEAR_SIZE + term_count);
            S_BHH_REQ, S_BHH_WAIT:
                mem_addr = addr_t'(`BHH_BASE + neuron_count);
            S_IH_REQ, S_IH_WAIT:
                mem_addr = addr_t'(`WIH_BASE + neuron_count * `EMBEDDING_SIZE + term_count);
            S_BIH_REQ, S_BIH_WAIT:
                mem_addr = addr_t'(`BIH_BASE + neuron_count);
            default:
                mem_addr = '0;
        endcase
    end

    always_comb
    begin
        if (state == S_IH_WAIT)
            operand_src = SRC_EMB;
        else
            operand_src = SRC_HIDDEN;
    end

    assign mem_req       = state inside {S_EMB_REQ, S_HH_REQ, S_BHH_REQ, S_IH_REQ, S_BIH_REQ};
    assign busy          = (state != S_IDLE);
    assign done          = (state == S_COMMIT);      // Last busy cycle
    assign commit        = (state == S_COMMIT);
    assign acc_clear     = (state == S_CLEAR);
    assign emb_write     = (state == S_EMB_WAIT) && mem_valid;
    assign emb_index     = term_count[`EMB_IDX_W-1:0];
    assign term_valid    = mem_valid && (state inside {S_HH_WAIT, S_BHH_WAIT,
                                                       S_IH_WAIT, S_BIH_WAIT});
    assign term_is_bias  = state inside {S_BHH_WAIT, S_BIH_WAIT};
    assign operand_index = term_count;
    assign hidden_write  = (state == S_DRAIN) && pipe_empty;
    assign hidden_index  = neuron_count;

endmodule

// ==== src/rnn_pkg.sv ====
`include "rnn_defs.svh"

package rnn_pkg;

    typedef logic signed [`WORD_W-1:0] word_t;    // Q8.8 value
    typedef logic [`ADDR_W-1:0]        addr_t;
    typedef logic [`TOKEN_W-1:0]       token_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_EMB_REQ,
        S_EMB_WAIT,
        S_CLEAR,
        S_HH_REQ,
        S_HH_WAIT,
        S_BHH_REQ,
        S_BHH_WAIT,
        S_IH_REQ,
        S_IH_WAIT,
        S_BIH_REQ,
        S_BIH_WAIT,
        S_DRAIN,
        S_COMMIT
    } seq_state_t;

    typedef enum logic {
        SRC_EMB,
        SRC_HIDDEN
    } operand_src_t;

endpackage

// ==== src/rnn_defs.svh ====
`ifndef RNN_DEFS_SVH
`define RNN_DEFS_SVH

// Network sizes
`define VOCAB_SIZE      76
`define EMBEDDING_SIZE  4
`define LINEAR_SIZE     8

// Word and index widths
`define WORD_W          16
`define FRAC_BITS       8              // Q8.8
`define ADDR_W          9
`define TOKEN_W         7
`define EMB_IDX_W       2
`define HID_IDX_W       3

// Word memory layout
`define EMB_BASE        0
`define WIH_BASE        (`VOCAB_SIZE * `EMBEDDING_SIZE)
`define WHH_BASE        (`WIH_BASE + `EMBEDDING_SIZE * `LINEAR_SIZE)
`define BIH_BASE        (`WHH_BASE + `LINEAR_SIZE * `LINEAR_SIZE)
`define BHH_BASE        (`BIH_BASE + `LINEAR_SIZE)
`define MEM_WORDS       (`BHH_BASE + `LINEAR_SIZE)

`endif
